/* logic/dptx_pkg.sv */
// Link symbol, register and address types with link symbol and register constants
`default_nettype none

package dptx_pkg;

    // Widths with a meaning
    typedef logic [7:0]  sym_t;         // One link symbol
    typedef logic [3:0]  axi_addr_t;    // Register address
    typedef logic [31:0] axi_data_t;    // Register data
    typedef logic [15:0] lfsr_t;        // Scrambler state

    // Main link or training pattern select
    typedef enum logic [1:0]
    {
        trn_main = 2'd0,
        trn_tps1 = 2'd1,
        trn_tps2 = 2'd2
    } trn_sel_t;

    // Link symbols
    localparam sym_t sym_d10_2 = 8'h4A;     // TPS1 symbol
    localparam sym_t sym_k28_5 = 8'hBC;     // Comma
    localparam sym_t sym_d11_6 = 8'hCB;
    localparam sym_t sym_k28_0 = 8'h1C;     // Scrambler reset (SR)

    // LFSR start value, after reset and after every SR
    localparam lfsr_t lfsr_seed = 16'hFFFF;

    // Register map
    localparam axi_addr_t reg_ctrl_addr = 4'h0;
    localparam axi_addr_t reg_id_addr   = 4'h4;
    localparam axi_data_t link_id       = 32'h4450_5458;   // "DPTX"

    // CTRL field layout
    localparam int ctrl_w = 5;      // Lane code, training select, scrambler enable

    // AXI response code
    localparam logic [1:0] axi_resp_okay = 2'b00;

endpackage

`default_nettype wire

/* logic/dptx_ctl.sv */
// AXI4-Lite register slave with CTRL and ID registers and link configuration decode
`timescale 1ns/10ps
`default_nettype none

module dptx_ctl
#(
    parameter int lanes = 4             // Link lanes, 1, 2 or 4
)
(
    input  logic                clk,
    input  logic                rst,

    // Write address and data
    input  logic                awvalid,
    output logic                awready,
    input  dptx_pkg::axi_addr_t awaddr,
    input  logic                wvalid,
    output logic                wready,
    input  dptx_pkg::axi_data_t wdata,

    // Write response
    output logic                bvalid,
    input  logic                bready,
    output logic [1:0]          bresp,

    // Read address and data
    input  logic                arvalid,
    output logic                arready,
    input  dptx_pkg::axi_addr_t araddr,
    output logic                rvalid,
    input  logic                rready,
    output dptx_pkg::axi_data_t rdata,
    output logic [1:0]          rresp,

    // Link configuration
    output logic [lanes-1:0]    lane_en,    // Active lane mask
    output dptx_pkg::trn_sel_t  trn_sel,    // Path select
    output logic                scrm_act    // Scrambler active
);

    import dptx_pkg::*;

    // Write channel states
    typedef enum logic [1:0]
    {
        wr_idle,        // Waiting for address and data together
        wr_acc,         // Ready high, handshake on both channels
        wr_resp         // Response pending
    } wr_st_t;

    wr_st_t             wr_st;
    logic               ctrl_wr;        // CTRL write strobe
    logic [ctrl_w-1:0]  ctrl_r;         // CTRL register
    trn_sel_t           sel_dec;        // Training select from write data

    // Lane code to mask, code 0 behaves as one lane
    function automatic logic [lanes-1:0] lane_mask(input logic [1:0] code);
        logic [3:0] m;
        case (code)
            2'd2:    m = 4'b0011;
            2'd3:    m = 4'b1111;
            default: m = 4'b0001;
        endcase
        return m[lanes-1:0];        // Upper bits dropped for narrow links
    endfunction

    // Write FSM
    always_ff @(posedge clk)
    begin
        if (rst)
            wr_st <= wr_idle;
        else
        begin
            case (wr_st)
                wr_idle:
                begin
                    if (awvalid && wvalid)  // Both channels needed
                        wr_st <= wr_acc;
                end
                wr_acc:
                    wr_st <= wr_resp;
                wr_resp:
                begin
                    if (bready)
                        wr_st <= wr_idle;
                end
                default:
                    wr_st <= wr_idle;
            endcase
        end
    end

    assign awready = (wr_st == wr_acc);
    assign wready  = (wr_st == wr_acc);
    assign bvalid  = (wr_st == wr_resp);
    assign bresp   = axi_resp_okay;     // Unmapped writes too

    // Commit on the edge where bvalid rises
    assign ctrl_wr = (wr_st == wr_acc) && (awaddr == reg_ctrl_addr);

    // Select code 3 is not a pattern
    always_comb
    begin
        case (wdata[3:2])
            2'd1:    sel_dec = trn_tps1;
            2'd2:    sel_dec = trn_tps2;
            default: sel_dec = trn_main;
        endcase
    end

    // CTRL and the decoded link configuration
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            ctrl_r   <= '0;
            lane_en  <= lane_mask(2'd0);
            trn_sel  <= trn_main;
            scrm_act <= 1'b0;
        end
        else if (ctrl_wr)
        begin
            ctrl_r   <= wdata[ctrl_w-1:0];
            lane_en  <= lane_mask(wdata[1:0]);
            trn_sel  <= sel_dec;
            // Training patterns never scrambled
            scrm_act <= wdata[4] && (sel_dec == trn_main);
        end
    end

    // Read channel
    assign arready = !rvalid;           // One read in flight
    assign rresp   = axi_resp_okay;

    always_ff @(posedge clk)
    begin
        if (rst)
            rvalid <= 1'b0;
        else if (arvalid && arready)
            rvalid <= 1'b1;
        else if (rready)
            rvalid <= 1'b0;
    end

    // Read data, held while rvalid waits
    always_ff @(posedge clk)
    begin
        if (arvalid && arready)
        begin
            case (araddr)
                reg_ctrl_addr: rdata <= {{(32-ctrl_w){1'b0}}, ctrl_r};
                reg_id_addr:   rdata <= link_id;
                default:       rdata <= '0;    // Unmapped
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/dptx_trn.sv */
// Training pattern generator with main link select and lane gating
`timescale 1ns/10ps
`default_nettype none

module dptx_trn
#(
    parameter int lanes = 4             // Link lanes
)
(
    input  logic                clk,
    input  logic                rst,

    // Control
    input  logic [lanes-1:0]    lane_en,    // Active lane mask
    input  dptx_pkg::trn_sel_t  trn_sel,    // Path select

    // Main link stream
    input  logic [lanes*8-1:0]  in_dat,
    input  logic [lanes-1:0]    in_k,

    // Selected stream
    output logic [lanes*8-1:0]  trn_dat,
    output logic [lanes-1:0]    trn_k
);

    import dptx_pkg::*;

    trn_sel_t           sel_q;          // Select seen last cycle
    logic [1:0]         phase_q;        // TPS2 phase for the next symbol
    logic [1:0]         phase;          // TPS2 phase used this cycle
    sym_t               tps2_sym;
    logic               tps2_k;
    logic [lanes*8-1:0] nxt_dat;
    logic [lanes-1:0]   nxt_k;

    // Restart at K28.5 on any select change
    assign phase = (trn_sel != sel_q) ? 2'd0 : phase_q;

    // TPS2 cycle K28.5 D11.6 D10.2 D10.2
    always_comb
    begin
        tps2_k = 1'b0;
        case (phase)
            2'd0:
            begin
                tps2_sym = sym_k28_5;
                tps2_k   = 1'b1;        // Comma is the only control symbol
            end
            2'd1:    tps2_sym = sym_d11_6;
            default: tps2_sym = sym_d10_2;
        endcase
    end

    // Per lane path mux
    always_comb
    begin
        for (int i = 0; i < lanes; i++)
        begin
            if (!lane_en[i])
            begin
                nxt_dat[i*8 +: 8] = '0;     // Lane off
                nxt_k[i]          = 1'b0;
            end
            else
            begin
                case (trn_sel)
                    trn_tps1:
                    begin
                        nxt_dat[i*8 +: 8] = sym_d10_2;
                        nxt_k[i]          = 1'b0;
                    end
                    trn_tps2:
                    begin
                        nxt_dat[i*8 +: 8] = tps2_sym;
                        nxt_k[i]          = tps2_k;
                    end
                    default:
                    begin
                        nxt_dat[i*8 +: 8] = in_dat[i*8 +: 8];
                        nxt_k[i]          = in_k[i];
                    end
                endcase
            end
        end
    end

    // Output register and phase tracking
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            sel_q   <= trn_main;
            phase_q <= 2'd0;
            trn_dat <= '0;
            trn_k   <= '0;
        end
        else
        begin
            sel_q   <= trn_sel;
            phase_q <= phase + 2'd1;    // Wraps after the fourth symbol
            trn_dat <= nxt_dat;
            trn_k   <= nxt_k;
        end
    end

endmodule

`default_nettype wire

/* logic/dptx_skew.sv */
// Per-lane delay line for the inter-lane skew
`timescale 1ns/10ps
`default_nettype none

module dptx_skew
#(
    parameter int lane = 0              // Lane index, delay is twice this
)
(
    input  logic                clk,
    input  logic                rst,
    input  dptx_pkg::sym_t      lane_dat,
    input  logic                lane_k,
    output dptx_pkg::sym_t      skew_dat,
    output logic                skew_k
);

    import dptx_pkg::*;

    generate
        if (lane == 0)
        begin : gen_none
            // Lane 0 carries no skew
            assign skew_dat = lane_dat;
            assign skew_k   = lane_k;
        end
        else
        begin : gen_dly
            localparam int depth = 2 * lane;

            sym_t [depth-1:0] dat_sr;   // Newest symbol in stage 0
            logic [depth-1:0] k_sr;

            always_ff @(posedge clk)
            begin
                if (rst)
                begin
                    dat_sr <= '0;
                    k_sr   <= '0;
                end
                else
                begin
                    dat_sr <= {dat_sr[depth-2:0], lane_dat};
                    k_sr   <= {k_sr[depth-2:0], lane_k};
                end
            end

            assign skew_dat = dat_sr[depth-1];
            assign skew_k   = k_sr[depth-1];
        end
    endgenerate

endmodule

`default_nettype wire

/* logic/dptx_scrm.sv */
// Per-lane LFSR scrambler with reload on scrambler reset symbols
`timescale 1ns/10ps
`default_nettype none

module dptx_scrm
(
    input  logic                clk,
    input  logic                rst,

    // Control
    input  logic                scrm_act,   // Scramble data symbols

    // Lane input
    input  dptx_pkg::sym_t      lane_dat,
    input  logic                lane_k,

    // Lane output
    output dptx_pkg::sym_t      scr_dat,
    output logic                scr_k
);

    import dptx_pkg::*;

    lfsr_t  lfsr;           // Scrambler state
    lfsr_t  lfsr_nxt;       // State after eight steps
    sym_t   key;            // LFSR output bits for this symbol
    logic   sr;             // Scrambler reset symbol

    assign sr = lane_k && (lane_dat == sym_k28_0);

    // Eight steps of x^16+x^5+x^4+x^3+1
    always_comb
    begin
        lfsr_nxt = lfsr;
        for (int b = 0; b < 8; b++)
        begin
            key[b] = lfsr_nxt[15];      // First bit out lands in bit 0
            // Shift up, bit 15 feeds bit 0 and the taps at 3, 4 and 5
            lfsr_nxt = {lfsr_nxt[14:0], lfsr_nxt[15]}
                     ^ {10'd0, {3{lfsr_nxt[15]}}, 3'd0};
        end
    end

    // State runs every cycle, also when scrambling is off
    always_ff @(posedge clk)
    begin
        if (rst)
            lfsr <= lfsr_seed;
        else if (sr)
            lfsr <= lfsr_seed;          // Restart on SR
        else
            lfsr <= lfsr_nxt;
    end

    // Registered output
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            scr_dat <= '0;
            scr_k   <= 1'b0;
        end
        else
        begin
            scr_k <= lane_k;
            if (scrm_act && !lane_k)
                scr_dat <= lane_dat ^ key;      // Data symbol
            else
                scr_dat <= lane_dat;            // Control symbol or bypass
        end
    end

endmodule

`default_nettype wire

/* logic/dptx_lnk.sv */
// Link layer top with control, training and per-lane skew and scrambler chains
`timescale 1ns/10ps
`default_nettype none

module dptx_lnk
#(
    parameter int lanes = 4             // Link lanes, 1, 2 or 4
)
(
    input  logic                clk,
    input  logic                rst,

    // AXI4-Lite slave
    input  logic                awvalid,
    output logic                awready,
    input  dptx_pkg::axi_addr_t awaddr,
    input  logic                wvalid,
    output logic                wready,
    input  dptx_pkg::axi_data_t wdata,
    output logic                bvalid,
    input  logic                bready,
    output logic [1:0]          bresp,
    input  logic                arvalid,
    output logic                arready,
    input  dptx_pkg::axi_addr_t araddr,
    output logic                rvalid,
    input  logic                rready,
    output dptx_pkg::axi_data_t rdata,
    output logic [1:0]          rresp,

    // Symbol stream in, one symbol per lane per clock
    input  logic [lanes*8-1:0]  in_dat,
    input  logic [lanes-1:0]    in_k,

    // Toward the encoders
    output logic [lanes*8-1:0]  out_dat,
    output logic [lanes-1:0]    out_k
);

    import dptx_pkg::*;

    logic [lanes-1:0]   lane_en;        // Control to training
    trn_sel_t           trn_sel;
    logic               scrm_act;       // Control to every scrambler
    logic [lanes*8-1:0] trn_dat;
    logic [lanes-1:0]   trn_k;
    sym_t               skew_dat [lanes];
    logic [lanes-1:0]   skew_k;

    dptx_ctl
    #(
        .lanes      (lanes)
    )
    ctl_inst
    (
        .clk        (clk),
        .rst        (rst),
        .awvalid    (awvalid),
        .awready    (awready),
        .awaddr     (awaddr),
        .wvalid     (wvalid),
        .wready     (wready),
        .wdata      (wdata),
        .bvalid     (bvalid),
        .bready     (bready),
        .bresp      (bresp),
        .arvalid    (arvalid),
        .arready    (arready),
        .araddr     (araddr),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .rresp      (rresp),
        .lane_en    (lane_en),
        .trn_sel    (trn_sel),
        .scrm_act   (scrm_act)
    );

    dptx_trn
    #(
        .lanes      (lanes)
    )
    trn_inst
    (
        .clk        (clk),
        .rst        (rst),
        .lane_en    (lane_en),
        .trn_sel    (trn_sel),
        .in_dat     (in_dat),
        .in_k       (in_k),
        .trn_dat    (trn_dat),
        .trn_k      (trn_k)
    );

    // Skew then scramble, one chain per lane
    genvar i;
    generate
        for (i = 0; i < lanes; i++)
        begin : gen_lane
            dptx_skew
            #(
                .lane       (i)                 // Delay of 2i cycles
            )
            skew_inst
            (
                .clk        (clk),
                .rst        (rst),
                .lane_dat   (trn_dat[i*8 +: 8]),
                .lane_k     (trn_k[i]),
                .skew_dat   (skew_dat[i]),
                .skew_k     (skew_k[i])
            );

            dptx_scrm
            scrm_inst
            (
                .clk        (clk),
                .rst        (rst),
                .scrm_act   (scrm_act),
                .lane_dat   (skew_dat[i]),
                .lane_k     (skew_k[i]),
                .scr_dat    (out_dat[i*8 +: 8]),
                .scr_k      (out_k[i])
            );
        end
    endgenerate

endmodule

`default_nettype wire

/* tests/tb_dptx_model.svh */
// Reference model with LFSR steps, TPS2 sequence, path select and per-lane delay queues
`ifndef TB_DPTX_MODEL_SVH
`define TB_DPTX_MODEL_SVH

// Pre-scrambler symbols in flight, k in bit 8
logic [8:0]  dly_q [lanes][$];
logic [15:0] mdl_lfsr [lanes];      // Model scrambler state per lane
logic        mdl_sync [lanes];      // Set once an SR came out
int          tps_ph [lanes];        // Next TPS2 phase, -1 before the first comma

// One shift of x^16+x^5+x^4+x^3+1
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic [15:0] nxt;
    nxt = {s[14:0], 1'b0};
    if (s[15])
        nxt = nxt ^ 16'h0039;       // Low terms x^5, x^4, x^3 and 1
    return nxt;
endfunction

// Eight output bits, first one in bit 0
function automatic logic [7:0] scramble_key(input logic [15:0] s);
    logic [7:0]  key;
    logic [15:0] st;
    st = s;
    for (int b = 0; b < 8; b++)
    begin
        key[b] = st[15];
        st = lfsr_step(st);
    end
    return key;
endfunction

function automatic logic [15:0] advance_byte(input logic [15:0] s);
    logic [15:0] st;
    st = s;
    for (int b = 0; b < 8; b++)
        st = lfsr_step(st);
    return st;
endfunction

// K28.5 D11.6 D10.2 D10.2
function automatic logic [8:0] tps2_symbol(input int ph);
    case (ph)
        0:       return 9'h1BC;
        1:       return 9'h0CB;
        default: return 9'h04A;
    endcase
endfunction

// Training block output for one lane
function automatic logic [8:0] select_symbol(input int i, input logic [7:0] d, input logic k);
    if (!cfg_mask[i])
        return 9'h000;              // Lane off
    case (cfg_sel)
        2'd1:    return 9'h04A;     // TPS1
        2'd2:    return 9'h000;     // TPS2 tracked by phase instead
        default: return {k, d};
    endcase
endfunction

// Delay of 2+2i per lane, LFSR at its start value
function automatic void clear_model();
    for (int i = 0; i < lanes; i++)
    begin
        dly_q[i].delete();
        for (int n = 0; n < 2 + 2 * i; n++)
            dly_q[i].push_back(9'h000);
        mdl_lfsr[i] = 16'hFFFF;
        mdl_sync[i] = 1'b0;
        tps_ph[i]   = -1;
    end
endfunction

`endif

/* tests/tb_dptx_lnk.sv */
// Testbench for the link layer top with AXI tasks, random stream, lane checks and watchdog
`timescale 1ns/10ps
`default_nettype none

module tb_dptx_lnk;

    localparam int lanes     = 4;
    localparam int flush     = 10;      // Longer than the slowest lane
    localparam int main_len  = 200;
    localparam int scr_len   = 300;
    localparam int lane_len  = 150;
    localparam int tps_len   = 100;
    localparam int axi_ops   = 40;
    localparam int axi_wait  = 64;      // Per handshake
    localparam int wd_cycles = main_len + scr_len + 3 * lane_len + 3 * tps_len
                             + axi_ops * (2 * axi_wait + 4) + 200;

    logic               clk;
    logic               rst;
    logic               awvalid;
    logic               awready;
    logic [3:0]         awaddr;
    logic               wvalid;
    logic               wready;
    logic [31:0]        wdata;
    logic               bvalid;
    logic               bready;
    logic [1:0]         bresp;
    logic               arvalid;
    logic               arready;
    logic [3:0]         araddr;
    logic               rvalid;
    logic               rready;
    logic [31:0]        rdata;
    logic [1:0]         rresp;
    logic [lanes*8-1:0] in_dat;
    logic [lanes-1:0]   in_k;
    logic [lanes*8-1:0] out_dat;
    logic [lanes-1:0]   out_k;

    logic [31:0]        rng_state;      // LCG state
    logic [lanes-1:0]   cfg_mask;       // Expected lane mask
    logic [1:0]         cfg_sel;        // 0 main, 1 TPS1, 2 TPS2
    logic               cfg_scr;        // Scrambler enable as written
    logic [31:0]        rd_val;
    logic [31:0]        rnd;

    `include "tb_dptx_model.svh"

    dptx_lnk #(.lanes(lanes)) uut
    (
        .clk(clk), .rst(rst),
        .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
        .wvalid(wvalid), .wready(wready), .wdata(wdata),
        .bvalid(bvalid), .bready(bready), .bresp(bresp),
        .arvalid(arvalid), .arready(arready), .araddr(araddr),
        .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
        .in_dat(in_dat), .in_k(in_k), .out_dat(out_dat), .out_k(out_k)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;              // 20 ns period

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
            abort_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    // Called on a falling edge and returns on one
    task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
        int         n;
        logic       done;
        logic [31:0] r;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        n = 0;
        while (!(awready && wready))
        begin
            if (n >= axi_wait)
                abort_run("Write address and data were never accepted");
            @(negedge clk);
            n++;
        end
        @(negedge clk);                 // Handshake on the rising edge in between
        awvalid = 1'b0;
        wvalid  = 1'b0;
        done = 1'b0;
        n = 0;
        while (!done)
        begin
            if (n >= axi_wait)
                abort_run("Write response never completed");
            check_eq("bvalid", 32'(bvalid), 32'h1);                     // Held until bready
            check_eq("awready wready", 32'({awready, wready}), 32'h0);  // Up for one cycle only
            check_eq("bresp", 32'(bresp), 32'h0);
            r = lcg_next();
            bready = r[31];             // Random stall
            done = bvalid && bready;
            @(negedge clk);
            n++;
        end
        bready = 1'b0;
    endtask

    task automatic read_reg(input logic [3:0] addr, output logic [31:0] data);
        int         n;
        logic       done;
        logic [31:0] r;
        araddr  = addr;
        arvalid = 1'b1;
        n = 0;
        while (!arready)
        begin
            if (n >= axi_wait)
                abort_run("Read address was never accepted");
            @(negedge clk);
            n++;
        end
        @(negedge clk);
        arvalid = 1'b0;
        data = '0;
        done = 1'b0;
        n = 0;
        while (!done)
        begin
            if (n >= axi_wait)
                abort_run("Read data never completed");
            check_eq("rvalid", 32'(rvalid), 32'h1);     // Held until rready
            check_eq("arready", 32'(arready), 32'h0);   // One read in flight
            r = lcg_next();
            rready = r[31];
            if (rvalid && rready)
            begin
                data = rdata;
                check_eq("rresp", 32'(rresp), 32'h0);
                done = 1'b1;
            end
            @(negedge clk);
            n++;
        end
        rready = 1'b0;
    endtask

    // Write CTRL and mirror what the link should do
    task automatic set_link(input logic [1:0] code, input logic [1:0] sel, input logic scr);
        write_reg(4'h0, {27'd0, scr, sel, code});
        case (code)
            2'd2:    cfg_mask = 4'b0011;
            2'd3:    cfg_mask = 4'b1111;
            default: cfg_mask = 4'b0001;    // Code 0 is one lane too
        endcase
        cfg_sel = sel;
        cfg_scr = scr;
    endtask

    task automatic compare_lane(input int i, input logic [8:0] front, input logic scr_on);
        logic [8:0] got;
        logic       is_sr;
        got = {out_k[i], out_dat[i*8 +: 8]};
        if (cfg_sel == 2'd2 && cfg_mask[i])
        begin
            if (tps_ph[i] < 0)
            begin
                if (got == 9'h1BC)
                    tps_ph[i] = 1;      // Locked on the comma
            end
            else
            begin
                check_eq($sformatf("tps2 lane %0d", i), 32'(got), 32'(tps2_symbol(tps_ph[i])));
                tps_ph[i] = (tps_ph[i] + 1) % 4;
            end
        end
        else
        begin
            is_sr = front[8] && (front[7:0] == 8'h1C);
            check_eq($sformatf("out_k[%0d]", i), 32'(got[8]), 32'(front[8]));
            if (scr_on && !front[8])
            begin
                if (mdl_sync[i])        // Unknown LFSR phase before the first SR
                    check_eq($sformatf("out_dat[%0d]", i), 32'(got[7:0]),
                             32'(front[7:0] ^ scramble_key(mdl_lfsr[i])));
            end
            else
                check_eq($sformatf("out_dat[%0d]", i), 32'(got[7:0]), 32'(front[7:0]));
            if (is_sr)
            begin
                mdl_lfsr[i] = 16'hFFFF;
                mdl_sync[i] = 1'b1;
            end
            else
                mdl_lfsr[i] = advance_byte(mdl_lfsr[i]);
        end
    endtask

    // Random symbols on every lane with outputs checked after the flush
    task automatic run_stream(input int len, input logic sr_en);
        logic [31:0] r;
        logic [8:0]  front;
        logic        scr_on;
        scr_on = cfg_scr && (cfg_sel == 2'd0);     // Patterns stay plain
        for (int i = 0; i < lanes; i++)
        begin
            mdl_sync[i] = 1'b0;
            tps_ph[i]   = -1;
        end
        for (int c = 0; c < len; c++)
        begin
            for (int i = 0; i < lanes; i++)
            begin
                front = dly_q[i].pop_front();
                if (c >= flush)
                    compare_lane(i, front, scr_on);
                r = lcg_next();
                in_dat[i*8 +: 8] = r[31:24];
                in_k[i] = (r[23:21] == 3'd0);
                if (sr_en && r[20:17] == 4'd0)
                begin
                    in_dat[i*8 +: 8] = 8'h1C;   // K28.0
                    in_k[i] = 1'b1;
                end
                dly_q[i].push_back(select_symbol(i, in_dat[i*8 +: 8], in_k[i]));
            end
            @(negedge clk);
        end
        for (int i = 0; i < lanes; i++)
        begin
            if (cfg_sel == 2'd2 && cfg_mask[i] && tps_ph[i] < 0)
                abort_run($sformatf("No K28.5 seen on lane %0d during TPS2", i));
            if (scr_on && cfg_mask[i] && !mdl_sync[i])
                abort_run($sformatf("No scrambler reset seen on lane %0d", i));
        end
    endtask

    initial
    begin
        repeat (wd_cycles) @(posedge clk);
        abort_run($sformatf("Watchdog expired after %0d cycles", wd_cycles));
    end

    initial
    begin
        rng_state = 32'h42a2_8b95;
        rst = 1'b1;
        {awvalid, wvalid, bready, arvalid, rready} = '0;
        awaddr = '0;
        wdata  = '0;
        araddr = '0;
        in_dat = '0;
        in_k   = '0;
        cfg_mask = 4'b0001;
        cfg_sel  = 2'd0;
        cfg_scr  = 1'b0;
        clear_model();
        repeat (3) @(negedge clk);
        rst = 1'b0;

        // Reset state and registers
        check_eq("out_dat", out_dat, 32'h0);
        check_eq("out_k", 32'(out_k), 32'h0);
        check_eq("awready wready bvalid rvalid", 32'({awready, wready, bvalid, rvalid}), 32'h0);
        check_eq("arready", 32'(arready), 32'h1);       // Read address open after reset
        read_reg(4'h4, rd_val);
        check_eq("rdata ID", rd_val, 32'h4450_5458);
        write_reg(4'h4, 32'hFFFF_FFFF);             // Read-only
        read_reg(4'h4, rd_val);
        check_eq("rdata ID after write", rd_val, 32'h4450_5458);
        rnd = lcg_next();
        write_reg(4'h8, rnd);
        read_reg(4'h8, rd_val);
        check_eq("rdata unmapped", rd_val, 32'h0);
        for (int n = 0; n < 12; n++)
        begin
            rnd = lcg_next();
            write_reg(4'h0, {27'd0, rnd[31:27]});
            read_reg(4'h0, rd_val);
            check_eq("rdata CTRL", rd_val, {27'd0, rnd[31:27]});
        end

        // Main path plain then scrambled
        set_link(2'd3, 2'd0, 1'b0);
        run_stream(main_len, 1'b0);
        set_link(2'd3, 2'd0, 1'b1);
        run_stream(scr_len, 1'b1);

        // Narrow links
        set_link(2'd1, 2'd0, 1'b0);
        run_stream(lane_len, 1'b0);
        set_link(2'd2, 2'd0, 1'b0);
        run_stream(lane_len, 1'b0);
        set_link(2'd0, 2'd0, 1'b0);
        run_stream(lane_len, 1'b0);

        // Training patterns with the scrambler enable set
        set_link(2'd3, 2'd1, 1'b1);
        run_stream(tps_len, 1'b1);
        set_link(2'd3, 2'd2, 1'b1);
        run_stream(tps_len, 1'b1);
        set_link(2'd2, 2'd2, 1'b1);
        run_stream(tps_len, 1'b0);

        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+tests
logic/dptx_pkg.sv
logic/dptx_ctl.sv
logic/dptx_trn.sv
logic/dptx_skew.sv
logic/dptx_scrm.sv
logic/dptx_lnk.sv
tests/tb_dptx_lnk.sv

/* Makefile */
TOP := tb_dptx_lnk
OBJ := obj_dir

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/10ps -f all.f --top-module dptx_lnk

sim:
	verilator --binary --timing --timescale 1ns/10ps -f all.f --top-module $(TOP) --Mdir $(OBJ)
	./$(OBJ)/V$(TOP)

clean:
	rm -rf $(OBJ)
